//--- rtl/core_cfg_pkg.sv
/* sizing constants for the issue stage and the
   rv32i opcode and funct7 values used by decode */
`default_nettype none

package core_cfg_pkg;

    // station geometry
    localparam int station_depth = 16;
    localparam int station_idx_w = $clog2(station_depth);

    // physical register space after rename
    localparam int num_phys_regs = 64;
    localparam int phys_tag_w = $clog2(num_phys_regs);

    // datapath and bookkeeping widths
    localparam int xlen = 32;
    localparam int order_w = 64;

    // major opcodes seen by the router
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_atomic = 7'b0101111;

    // funct7 of the M extension under op_reg
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

endpackage

`default_nettype wire

//--- rtl/issue_types_pkg.sv
/* physical tag type and the payloads carried by
   the alu and multiply stations and their launch ports */
`default_nettype none

package issue_types_pkg;

    // renamed register tag
    typedef logic [core_cfg_pkg::phys_tag_w-1:0] phys_tag_t;

    // alu side keeps pc and the raw word
    // execute re-decodes immediates from instr
    typedef struct packed {
        logic [core_cfg_pkg::xlen-1:0] pc;
        logic [core_cfg_pkg::xlen-1:0] instr;
        phys_tag_t rd;
        phys_tag_t rs1;
        phys_tag_t rs2;
        logic [core_cfg_pkg::order_w-1:0] order;
    } alu_entry_t;

    // multiply side only needs tags and the op select
    // funct3 picks mul, mulh, div, rem and friends
    typedef struct packed {
        phys_tag_t rd;
        phys_tag_t rs1;
        phys_tag_t rs2;
        logic [2:0] funct3;
        logic [core_cfg_pkg::order_w-1:0] order;
    } mul_entry_t;

endpackage

`default_nettype wire

//--- rtl/dispatch_decode.sv
/* dispatch decode: station routing, accept gate,
   jal target and instruction order counter */
`timescale 1ns/1ns
`default_nettype none

module dispatch_decode (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic flush,
    input  wire logic instr_valid,
    input  wire logic [core_cfg_pkg::xlen-1:0] instr_pc,
    input  wire logic [core_cfg_pkg::xlen-1:0] instr_word,
    input  wire issue_types_pkg::phys_tag_t rd_tag,
    input  wire issue_types_pkg::phys_tag_t rs1_tag,
    input  wire issue_types_pkg::phys_tag_t rs2_tag,
    input  wire logic alu_full,
    input  wire logic mul_full,
    output logic instr_ready,
    output logic alu_insert,
    output logic mul_insert,
    output logic jump_en,
    output logic [core_cfg_pkg::xlen-1:0] jump_pc,
    output issue_types_pkg::alu_entry_t alu_payload,
    output issue_types_pkg::mul_entry_t mul_payload
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic accept;
    logic is_mul;
    logic is_mem;
    logic is_jal;
    logic [core_cfg_pkg::xlen-1:0] j_imm;
    logic [core_cfg_pkg::order_w-1:0] order_q;

    assign opcode = instr_word[6:0];
    assign funct7 = instr_word[31:25];

    // both stations must have room, one slot is enough for either
    assign instr_ready = !alu_full && !mul_full && !flush;
    assign accept = instr_valid && instr_ready;

    always_comb begin
        is_mul = 1'b0;
        is_mem = 1'b0;
        is_jal = 1'b0;
        case (opcode)
            core_cfg_pkg::op_reg: is_mul = funct7 == core_cfg_pkg::funct7_muldiv;
            core_cfg_pkg::op_jal: is_jal = 1'b1;
            // jalr target needs rs1, resolved in the alu
            core_cfg_pkg::op_jalr: is_jal = 1'b0;
            // no address unit here, taken and dropped
            core_cfg_pkg::op_load, core_cfg_pkg::op_store, core_cfg_pkg::op_atomic: is_mem = 1'b1;
            default: is_mem = 1'b0;
        endcase
    end

    // everything not mul and not memory goes to the alu, jal included
    assign alu_insert = accept && !is_mul && !is_mem;
    assign mul_insert = accept && is_mul;

    // j-immediate, bit 0 always zero
    assign j_imm = {{(core_cfg_pkg::xlen - 20){instr_word[31]}}, instr_word[19:12],
                    instr_word[20], instr_word[30:21], 1'b0};
    assign jump_en = accept && is_jal;
    assign jump_pc = jump_en ? instr_pc + j_imm : '0;

    always_comb begin
        alu_payload.pc = instr_pc;
        alu_payload.instr = instr_word;
        alu_payload.rd = rd_tag;
        alu_payload.rs1 = rs1_tag;
        alu_payload.rs2 = rs2_tag;
        alu_payload.order = order_q;
        mul_payload.rd = rd_tag;
        mul_payload.rs1 = rs1_tag;
        mul_payload.rs2 = rs2_tag;
        mul_payload.funct3 = instr_word[14:12];
        mul_payload.order = order_q;
    end

    // sequence number, counts dropped memory ops too
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            order_q <= '0;
        end else if (flush) begin
            order_q <= '0;
        end else if (accept) begin
            order_q <= order_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/reservation_station.sv
/* reservation station with cdb wakeup, lowest-free allocation
   and highest-index ready select, payload type as parameter */
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
    parameter type entry_t = logic
) (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic flush,
    input  wire logic insert,
    input  wire entry_t insert_entry,
    input  wire issue_types_pkg::phys_tag_t src1_tag,
    input  wire issue_types_pkg::phys_tag_t src2_tag,
    input  wire logic src1_ready,
    input  wire logic src2_ready,
    input  wire logic cdb_valid,
    input  wire issue_types_pkg::phys_tag_t cdb_tag,
    input  wire logic take,
    output logic full,
    output logic pick_valid,
    output entry_t pick_entry
);

    localparam int depth = core_cfg_pkg::station_depth;

    // slot storage
    entry_t slot_entry [depth];
    issue_types_pkg::phys_tag_t slot_src1 [depth];
    issue_types_pkg::phys_tag_t slot_src2 [depth];
    logic [depth-1:0] slot_valid;
    logic [depth-1:0] slot_rdy1;
    logic [depth-1:0] slot_rdy2;

    // wakeup view including this cycle's broadcast
    logic [depth-1:0] wake1;
    logic [depth-1:0] wake2;
    logic [depth-1:0] ready_vec;
    logic ins_rdy1;
    logic ins_rdy2;

    logic [core_cfg_pkg::station_idx_w-1:0] pick_idx;
    logic [core_cfg_pkg::station_idx_w-1:0] free_idx;

    // incoming sources can be woken by the same broadcast
    assign ins_rdy1 = src1_ready || (cdb_valid && src1_tag == cdb_tag);
    assign ins_rdy2 = src2_ready || (cdb_valid && src2_tag == cdb_tag);

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            wake1[i] = slot_rdy1[i] || (cdb_valid && slot_src1[i] == cdb_tag);
            wake2[i] = slot_rdy2[i] || (cdb_valid && slot_src2[i] == cdb_tag);
            ready_vec[i] = slot_valid[i] && wake1[i] && wake2[i];
        end
    end

    // highest ready index wins, later iterations override
    always_comb begin
        pick_valid = 1'b0;
        pick_idx = '0;
        for (int i = 0; i < depth; i++) begin
            if (ready_vec[i]) begin
                pick_valid = 1'b1;
                pick_idx = i[core_cfg_pkg::station_idx_w-1:0];
            end
        end
    end

    assign pick_entry = slot_entry[pick_idx];

    // lowest free slot, scan downward
    always_comb begin
        free_idx = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = i[core_cfg_pkg::station_idx_w-1:0];
            end
        end
    end

    assign full = &slot_valid;

    // occupancy
    // picked slot is valid, free slot is not, so no index clash
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
        end else if (flush) begin
            slot_valid <= '0;
        end else begin
            if (take && pick_valid) begin
                slot_valid[pick_idx] <= 1'b0;
            end
            if (insert) begin
                slot_valid[free_idx] <= 1'b1;
            end
        end
    end

    // ready bits latch the wakeup, new entry overrides its slot
    always_ff @(posedge clk) begin
        slot_rdy1 <= wake1;
        slot_rdy2 <= wake2;
        if (insert) begin
            slot_rdy1[free_idx] <= ins_rdy1;
            slot_rdy2[free_idx] <= ins_rdy2;
            slot_entry[free_idx] <= insert_entry;
            slot_src1[free_idx] <= src1_tag;
            slot_src2[free_idx] <= src2_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_launch.sv
/* launch side: two-stage alu issue pipeline and
   single-outstanding multiply control with busy flag */
`timescale 1ns/1ns
`default_nettype none

module issue_launch (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic flush,
    input  wire logic alu_pick_valid,
    input  wire issue_types_pkg::alu_entry_t alu_pick,
    input  wire logic mul_pick_valid,
    input  wire issue_types_pkg::mul_entry_t mul_pick,
    input  wire logic mul_done,
    output logic alu_take,
    output logic mul_take,
    output logic alu_issue_valid,
    output issue_types_pkg::alu_entry_t alu_issue_entry,
    output logic mul_issue_valid,
    output issue_types_pkg::mul_entry_t mul_issue_entry
);

    // first alu launch stage
    logic alu_s1_valid;
    issue_types_pkg::alu_entry_t alu_s1_entry;

    // one multiply in flight at a time
    logic mul_busy;

    // alu never stalls, every pick is taken
    assign alu_take = alu_pick_valid;

    // done cycle still counts as busy, next take one cycle later
    assign mul_take = mul_pick_valid && !mul_busy && !mul_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_s1_valid <= 1'b0;
            alu_issue_valid <= 1'b0;
        end else if (flush) begin
            alu_s1_valid <= 1'b0;
            alu_issue_valid <= 1'b0;
        end else begin
            alu_s1_valid <= alu_take;
            alu_issue_valid <= alu_s1_valid;
        end
    end

    // payload follows the valid chain
    always_ff @(posedge clk) begin
        alu_s1_entry <= alu_pick;
        alu_issue_entry <= alu_s1_entry;
    end

    // launch pulse and busy tracking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_busy <= 1'b0;
            mul_issue_valid <= 1'b0;
        end else if (flush) begin
            mul_busy <= 1'b0;
            mul_issue_valid <= 1'b0;
        end else begin
            mul_issue_valid <= mul_take;
            if (mul_take) begin
                mul_busy <= 1'b1;
            end else if (mul_done) begin
                mul_busy <= 1'b0;
            end
        end
    end

    // operand tags stay visible until the next launch
    always_ff @(posedge clk) begin
        if (mul_take) begin
            mul_issue_entry <= mul_pick;
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_stage.sv
/* issue stage top: decode, alu and multiply stations, launch */
`timescale 1ns/1ns
`default_nettype none

module issue_stage (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic flush,
    input  wire logic instr_valid,
    input  wire logic [core_cfg_pkg::xlen-1:0] instr_pc,
    input  wire logic [core_cfg_pkg::xlen-1:0] instr_word,
    input  wire issue_types_pkg::phys_tag_t rd_tag,
    input  wire issue_types_pkg::phys_tag_t rs1_tag,
    input  wire issue_types_pkg::phys_tag_t rs2_tag,
    input  wire logic rs1_ready,
    input  wire logic rs2_ready,
    input  wire logic cdb_valid,
    input  wire issue_types_pkg::phys_tag_t cdb_tag,
    input  wire logic mul_done,
    output logic instr_ready,
    output logic jump_en,
    output logic [core_cfg_pkg::xlen-1:0] jump_pc,
    output logic alu_issue_valid,
    output issue_types_pkg::alu_entry_t alu_issue_entry,
    output logic mul_issue_valid,
    output issue_types_pkg::mul_entry_t mul_issue_entry
);

    // decode to stations
    logic alu_insert;
    logic mul_insert;
    logic alu_full;
    logic mul_full;
    issue_types_pkg::alu_entry_t alu_payload;
    issue_types_pkg::mul_entry_t mul_payload;

    // stations to launch
    logic alu_pick_valid;
    logic mul_pick_valid;
    logic alu_take;
    logic mul_take;
    issue_types_pkg::alu_entry_t alu_pick;
    issue_types_pkg::mul_entry_t mul_pick;

    dispatch_decode i_dispatch_decode (
        .clk(clk),
        .arst_n(arst_n),
        .flush(flush),
        .instr_valid(instr_valid),
        .instr_pc(instr_pc),
        .instr_word(instr_word),
        .rd_tag(rd_tag),
        .rs1_tag(rs1_tag),
        .rs2_tag(rs2_tag),
        .alu_full(alu_full),
        .mul_full(mul_full),
        .instr_ready(instr_ready),
        .alu_insert(alu_insert),
        .mul_insert(mul_insert),
        .jump_en(jump_en),
        .jump_pc(jump_pc),
        .alu_payload(alu_payload),
        .mul_payload(mul_payload)
    );

    // same source tags and ready bits feed both stations
    reservation_station #(
        .entry_t(issue_types_pkg::alu_entry_t)
    ) i_alu_station (
        .clk(clk),
        .arst_n(arst_n),
        .flush(flush),
        .insert(alu_insert),
        .insert_entry(alu_payload),
        .src1_tag(rs1_tag),
        .src2_tag(rs2_tag),
        .src1_ready(rs1_ready),
        .src2_ready(rs2_ready),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .take(alu_take),
        .full(alu_full),
        .pick_valid(alu_pick_valid),
        .pick_entry(alu_pick)
    );

    reservation_station #(
        .entry_t(issue_types_pkg::mul_entry_t)
    ) i_mul_station (
        .clk(clk),
        .arst_n(arst_n),
        .flush(flush),
        .insert(mul_insert),
        .insert_entry(mul_payload),
        .src1_tag(rs1_tag),
        .src2_tag(rs2_tag),
        .src1_ready(rs1_ready),
        .src2_ready(rs2_ready),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .take(mul_take),
        .full(mul_full),
        .pick_valid(mul_pick_valid),
        .pick_entry(mul_pick)
    );

    issue_launch i_issue_launch (
        .clk(clk),
        .arst_n(arst_n),
        .flush(flush),
        .alu_pick_valid(alu_pick_valid),
        .alu_pick(alu_pick),
        .mul_pick_valid(mul_pick_valid),
        .mul_pick(mul_pick),
        .mul_done(mul_done),
        .alu_take(alu_take),
        .mul_take(mul_take),
        .alu_issue_valid(alu_issue_valid),
        .alu_issue_entry(alu_issue_entry),
        .mul_issue_valid(mul_issue_valid),
        .mul_issue_entry(mul_issue_entry)
    );

endmodule

`default_nettype wire

//--- test/issue_stage_props.sv
/* bound assertions on multiply launch, reset quiet outputs
   and station inserts */
`timescale 1ns/1ns
`default_nettype none

module issue_stage_props (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic flush,
    input wire logic mul_done,
    input wire logic alu_take,
    input wire logic mul_take,
    input wire logic mul_issue_valid,
    input wire logic alu_issue_valid,
    input wire logic jump_en,
    input wire logic instr_ready,
    input wire logic alu_insert,
    input wire logic mul_insert
);

    localparam int depth = core_cfg_pkg::station_depth;

    // multiply in flight, from take until done
    logic busy_q;

    // entries held per station, counted from inserts and takes
    logic [core_cfg_pkg::station_idx_w:0] alu_cnt;
    logic [core_cfg_pkg::station_idx_w:0] mul_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
        end else if (flush) begin
            busy_q <= 1'b0;
        end else if (mul_take) begin
            busy_q <= 1'b1;
        end else if (mul_done) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_cnt <= '0;
            mul_cnt <= '0;
        end else if (flush) begin
            alu_cnt <= '0;
            mul_cnt <= '0;
        end else begin
            if (alu_insert && !alu_take) begin
                alu_cnt <= alu_cnt + 1'b1;
            end else if (!alu_insert && alu_take) begin
                alu_cnt <= alu_cnt - 1'b1;
            end
            if (mul_insert && !mul_take) begin
                mul_cnt <= mul_cnt + 1'b1;
            end else if (!mul_insert && mul_take) begin
                mul_cnt <= mul_cnt - 1'b1;
            end
        end
    end

    // launch pulse is a single cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        mul_issue_valid |=> !mul_issue_valid)
        else $error("multiply launch held for two cycles");

    assert property (@(posedge clk) disable iff (!arst_n) busy_q |-> !mul_take)
        else $error("multiply launch while unit busy");

    // first edge out of reset
    assert property (@(posedge clk) $rose(arst_n) |->
        !alu_issue_valid && !mul_issue_valid && !jump_en && instr_ready)
        else $error("outputs not quiet after reset");

    assert property (@(posedge clk) disable iff (!arst_n)
        !(alu_insert && alu_cnt == depth) && !(mul_insert && mul_cnt == depth))
        else $error("insert into a full station");

endmodule

bind issue_stage issue_stage_props i_issue_stage_props (
    .clk(clk),
    .arst_n(arst_n),
    .flush(flush),
    .mul_done(mul_done),
    .alu_take(alu_take),
    .mul_take(mul_take),
    .mul_issue_valid(mul_issue_valid),
    .alu_issue_valid(alu_issue_valid),
    .jump_en(jump_en),
    .instr_ready(instr_ready),
    .alu_insert(alu_insert),
    .mul_insert(mul_insert)
);

`default_nettype wire

//--- test/issue_stage_tb.sv
/* issue stage testbench: stimulus, reference model of stations
   and launch timing, compare tasks, watchdog */
`timescale 1ns/1ns
`default_nettype none

module issue_stage_tb;

    localparam int depth = core_cfg_pkg::station_depth;
    localparam int test_cycles = 600;

    logic clk;
    logic arst_n;
    logic flush;
    logic instr_valid;
    logic [core_cfg_pkg::xlen-1:0] instr_pc;
    logic [core_cfg_pkg::xlen-1:0] instr_word;
    issue_types_pkg::phys_tag_t rd_tag;
    issue_types_pkg::phys_tag_t rs1_tag;
    issue_types_pkg::phys_tag_t rs2_tag;
    logic rs1_ready;
    logic rs2_ready;
    logic cdb_valid;
    issue_types_pkg::phys_tag_t cdb_tag;
    logic mul_done;
    logic instr_ready;
    logic jump_en;
    logic [core_cfg_pkg::xlen-1:0] jump_pc;
    logic alu_issue_valid;
    issue_types_pkg::alu_entry_t alu_issue_entry;
    logic mul_issue_valid;
    issue_types_pkg::mul_entry_t mul_issue_entry;

    int value_errors = 0;
    int other_errors = 0;
    logic [31:0] rng = 32'hcbf0_652c;

    // model state, station 0 alu, station 1 multiply
    logic m_valid [2][depth];
    logic m_r1 [2][depth];
    logic m_r2 [2][depth];
    issue_types_pkg::phys_tag_t m_t1 [2][depth];
    issue_types_pkg::phys_tag_t m_t2 [2][depth];
    issue_types_pkg::alu_entry_t m_alu [depth];
    issue_types_pkg::mul_entry_t m_mul [depth];
    logic [core_cfg_pkg::order_w-1:0] m_order;
    logic m_s1_valid;
    logic m_alu_out_valid;
    logic m_mul_busy;
    logic m_mul_out_valid;
    issue_types_pkg::alu_entry_t m_s1_entry;
    issue_types_pkg::alu_entry_t m_alu_out;
    issue_types_pkg::mul_entry_t m_mul_out;

    issue_stage i_issue_stage (
        .clk(clk), .arst_n(arst_n), .flush(flush), .instr_valid(instr_valid),
        .instr_pc(instr_pc), .instr_word(instr_word), .rd_tag(rd_tag),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rs1_ready(rs1_ready),
        .rs2_ready(rs2_ready), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .mul_done(mul_done), .instr_ready(instr_ready), .jump_en(jump_en),
        .jump_pc(jump_pc), .alu_issue_valid(alu_issue_valid),
        .alu_issue_entry(alu_issue_entry), .mul_issue_valid(mul_issue_valid),
        .mul_issue_entry(mul_issue_entry)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // jal target, j-immediate scattered over the upper word
    function automatic logic [31:0] expected_jump_pc(input logic [31:0] pc,
                                                     input logic [31:0] word);
        logic [20:0] imm;
        imm = {word[31], word[19:12], word[20], word[30:21], 1'b0};
        return pc + {{11{imm[20]}}, imm};
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [core_cfg_pkg::xlen-1:0] got,
                              input logic [core_cfg_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_alu_entry(input string name, input issue_types_pkg::alu_entry_t got,
                                   input issue_types_pkg::alu_entry_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mul_entry(input string name, input issue_types_pkg::mul_entry_t got,
                                   input issue_types_pkg::mul_entry_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < depth; i++) begin
                m_valid[s][i] = 1'b0;
            end
        end
        m_order = '0;
        m_s1_valid = 1'b0;
        m_alu_out_valid = 1'b0;
        m_mul_busy = 1'b0;
        m_mul_out_valid = 1'b0;
    endtask

    function automatic logic src_awake(input logic rdy, input issue_types_pkg::phys_tag_t t);
        return rdy || (cdb_valid && t == cdb_tag);
    endfunction

    // compare at the falling edge, then step the model over the next rising edge
    always @(negedge clk) begin : compare_proc
        logic full_a;
        logic full_m;
        logic exp_ready;
        logic accept;
        logic is_mul;
        logic is_mem;
        logic exp_jump;
        logic pick_v [2];
        logic take [2];
        int pick_i [2];
        int free_i [2];
        logic [6:0] op;
        issue_types_pkg::alu_entry_t new_alu;
        issue_types_pkg::mul_entry_t new_mul;
        if (!arst_n) begin
            clear_model();
        end else begin
            full_a = 1'b1;
            full_m = 1'b1;
            for (int i = 0; i < depth; i++) begin
                full_a = full_a && m_valid[0][i];
                full_m = full_m && m_valid[1][i];
            end
            exp_ready = !full_a && !full_m && !flush;
            accept = instr_valid && exp_ready;
            op = instr_word[6:0];
            is_mul = op == core_cfg_pkg::op_reg && instr_word[31:25] == core_cfg_pkg::funct7_muldiv;
            is_mem = op == core_cfg_pkg::op_load || op == core_cfg_pkg::op_store ||
                     op == core_cfg_pkg::op_atomic;
            exp_jump = accept && op == core_cfg_pkg::op_jal;
            check_bit("instr_ready", instr_ready, exp_ready);
            check_bit("jump_en", jump_en, exp_jump);
            check_addr("jump_pc", jump_pc, exp_jump ? expected_jump_pc(instr_pc, instr_word) : '0);
            check_bit("alu_issue_valid", alu_issue_valid, m_alu_out_valid);
            if (m_alu_out_valid) begin
                check_alu_entry("alu_issue_entry", alu_issue_entry, m_alu_out);
            end
            check_bit("mul_issue_valid", mul_issue_valid, m_mul_out_valid);
            if (m_mul_out_valid) begin
                check_mul_entry("mul_issue_entry", mul_issue_entry, m_mul_out);
            end
            if (flush) begin
                clear_model();
            end else begin
                // highest ready slot, lowest free slot
                for (int s = 0; s < 2; s++) begin
                    pick_v[s] = 1'b0;
                    pick_i[s] = 0;
                    free_i[s] = -1;
                    for (int i = 0; i < depth; i++) begin
                        if (m_valid[s][i] && src_awake(m_r1[s][i], m_t1[s][i]) &&
                            src_awake(m_r2[s][i], m_t2[s][i])) begin
                            pick_v[s] = 1'b1;
                            pick_i[s] = i;
                        end
                        if (!m_valid[s][i] && free_i[s] < 0) begin
                            free_i[s] = i;
                        end
                    end
                end
                take[0] = pick_v[0];
                take[1] = pick_v[1] && !m_mul_busy && !mul_done;
                m_alu_out_valid = m_s1_valid;
                m_alu_out = m_s1_entry;
                m_s1_valid = take[0];
                m_s1_entry = m_alu[pick_i[0]];
                m_mul_out_valid = take[1];
                if (take[1]) begin
                    m_mul_out = m_mul[pick_i[1]];
                    m_mul_busy = 1'b1;
                end else if (mul_done) begin
                    m_mul_busy = 1'b0;
                end
                for (int s = 0; s < 2; s++) begin
                    if (take[s]) begin
                        m_valid[s][pick_i[s]] = 1'b0;
                    end
                    for (int i = 0; i < depth; i++) begin
                        m_r1[s][i] = src_awake(m_r1[s][i], m_t1[s][i]);
                        m_r2[s][i] = src_awake(m_r2[s][i], m_t2[s][i]);
                    end
                end
                new_alu.pc = instr_pc;
                new_alu.instr = instr_word;
                new_alu.rd = rd_tag;
                new_alu.rs1 = rs1_tag;
                new_alu.rs2 = rs2_tag;
                new_alu.order = m_order;
                new_mul.rd = rd_tag;
                new_mul.rs1 = rs1_tag;
                new_mul.rs2 = rs2_tag;
                new_mul.funct3 = instr_word[14:12];
                new_mul.order = m_order;
                if (accept && !is_mem) begin
                    if (is_mul) begin
                        m_mul[free_i[1]] = new_mul;
                    end else begin
                        m_alu[free_i[0]] = new_alu;
                    end
                    m_valid[is_mul][free_i[is_mul]] = 1'b1;
                    m_t1[is_mul][free_i[is_mul]] = rs1_tag;
                    m_t2[is_mul][free_i[is_mul]] = rs2_tag;
                    m_r1[is_mul][free_i[is_mul]] = src_awake(rs1_ready, rs1_tag);
                    m_r2[is_mul][free_i[is_mul]] = src_awake(rs2_ready, rs2_tag);
                end
                if (accept) begin
                    m_order = m_order + 1'b1;
                end
            end
        end
    end

    // all drivers start and end 10 ns after a rising edge
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic send_instr(input logic [31:0] pc, input logic [31:0] word,
                              input logic [5:0] rd, input logic [5:0] s1, input logic [5:0] s2,
                              input logic r1, input logic r2);
        logic acc;
        instr_pc = pc;
        instr_word = word;
        rd_tag = rd;
        rs1_tag = s1;
        rs2_tag = s2;
        rs1_ready = r1;
        rs2_ready = r2;
        instr_valid = 1'b1;
        do begin
            @(negedge clk);
            acc = instr_ready;
            @(posedge clk);
            #10;
        end while (!acc);
        instr_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [5:0] t);
        cdb_valid = 1'b1;
        cdb_tag = t;
        idle(1);
        cdb_valid = 1'b0;
    endtask

    task automatic pulse_done();
        mul_done = 1'b1;
        idle(1);
        mul_done = 1'b0;
    endtask

    function automatic logic [31:0] alu_word();
        logic [31:0] r;
        r = next_rand();
        return {7'h00, r[17:0], core_cfg_pkg::op_reg};
    endfunction

    function automatic logic [31:0] mul_word();
        logic [31:0] r;
        r = next_rand();
        return {core_cfg_pkg::funct7_muldiv, r[17:0], core_cfg_pkg::op_reg};
    endfunction

    initial begin
        logic [31:0] r;
        arst_n = 1'b0;
        flush = 1'b0;
        instr_valid = 1'b0;
        instr_pc = '0;
        instr_word = '0;
        rd_tag = '0;
        rs1_tag = '0;
        rs2_tag = '0;
        rs1_ready = 1'b0;
        rs2_ready = 1'b0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        mul_done = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        arst_n = 1'b1;
        idle(2);

        // routing of ready alu and multiply ops
        send_instr(32'h100, alu_word(), 6'd1, 6'd2, 6'd3, 1'b1, 1'b1);
        send_instr(32'h104, mul_word(), 6'd4, 6'd5, 6'd6, 1'b1, 1'b1);
        idle(6);
        pulse_done();

        // jal targets mixed with dropped loads and stores
        for (int k = 0; k < 20; k++) begin
            r = next_rand();
            send_instr(next_rand() & 32'hffff_fffc, {r[31:7], core_cfg_pkg::op_jal},
                       r[5:0], r[11:6], r[17:12], 1'b1, 1'b1);
            r = next_rand();
            send_instr(32'h200 + k, {r[31:7], (k % 2) ? core_cfg_pkg::op_store :
                       core_cfg_pkg::op_load}, r[5:0], r[11:6], r[17:12], 1'b1, 1'b1);
        end
        idle(5);

        // wakeup by cdb, one source at a time
        send_instr(32'h300, alu_word(), 6'd9, 6'd10, 6'd11, 1'b0, 1'b0);
        send_instr(32'h304, mul_word(), 6'd12, 6'd11, 6'd10, 1'b0, 1'b1);
        idle(3);
        broadcast(6'd10);
        idle(2);
        broadcast(6'd11);
        idle(5);
        pulse_done();

        // multiply back-pressure with done held low
        for (int k = 0; k < 3; k++) begin
            send_instr(32'h400 + 4 * k, mul_word(), 6'(20 + k), 6'd1, 6'd2, 1'b1, 1'b1);
        end
        idle(8);
        pulse_done();
        idle(4);
        pulse_done();
        idle(4);
        pulse_done();
        idle(3);

        // fill the alu station, then flush
        for (int k = 0; k < depth; k++) begin
            send_instr(32'h500 + 4 * k, alu_word(), 6'd30, 6'(40 + k), 6'd63, 1'b0, 1'b0);
        end
        idle(3);
        flush = 1'b1;
        idle(1);
        flush = 1'b0;
        idle(2);
        send_instr(32'h600, alu_word(), 6'd7, 6'd8, 6'd9, 1'b1, 1'b1);
        idle(5);

        $display("errors: value %0d other %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((test_cycles + 200) * 100);
        other_errors++;
        $display("timeout: tests did not reach the end");
        $display("errors: value %0d other %0d", value_errors, other_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/core_cfg_pkg.sv
rtl/issue_types_pkg.sv
rtl/dispatch_decode.sv
rtl/reservation_station.sv
rtl/issue_launch.sv
rtl/issue_stage.sv
test/issue_stage_props.sv
test/issue_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module issue_stage_tb \
    -o issue_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/issue_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
    exit 0
fi
exit 1
